// ==== all.f ====
+incdir+hdl
hdl/sram_pkg.sv
hdl/ram_bytes.sv
hdl/sram_port.sv
hdl/sram_arbiter.sv
hdl/sram_dual_top.sv
tb/tb_sram_dual.sv

// ==== hdl/ram_bytes.sv ====
// ==================================================
// Byte-strobed single-port RAM
// Per-lane writes, one cycle registered read
// ==================================================
`include "sram_settings.svh"

module ram_bytes
(
    input  logic                 i_clk,
    input  logic                 i_en,      // Access enable
    input  sram_pkg::word_addr_t i_addr,
    input  logic                 i_wena,    // Write when enabled
    input  sram_pkg::strb_t      i_wstrb,   // Byte lanes to write
    input  sram_pkg::data_t      i_wdata,
    output sram_pkg::data_t      o_rdata    // Valid the cycle after the access
);

    // Array of words, each split into byte lanes
    logic [`SRAM_DATA_BYTES-1:0][7:0] mem [`SRAM_WORDS];

    always_ff @(posedge i_clk)
    begin
        if (i_en)
        begin
            if (i_wena)
            begin
                for (int b = 0; b < `SRAM_DATA_BYTES; b++)
                begin
                    if (i_wstrb[b])
                    begin
                        mem[i_addr][b] <= i_wdata[8*b +: 8];  // Strobed lane only
                    end
                end
            end
            o_rdata <= mem[i_addr];   // Old contents on a write cycle
        end
    end

endmodule : ram_bytes

// ==== hdl/sram_arbiter.sv ====
// ==================================================
// Two-port round-robin RAM arbiter
// Grants one pending port, steers read returns
// ==================================================
module sram_arbiter
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_cpu_pend,
    input  sram_pkg::word_addr_t i_cpu_addr,
    input  logic                 i_cpu_write,
    input  sram_pkg::strb_t      i_cpu_strb,
    input  sram_pkg::data_t      i_cpu_wdata,
    input  logic                 i_dma_pend,
    input  sram_pkg::word_addr_t i_dma_addr,
    input  logic                 i_dma_write,
    input  sram_pkg::strb_t      i_dma_strb,
    input  sram_pkg::data_t      i_dma_wdata,
    output logic                 o_cpu_grant,
    output logic                 o_dma_grant,
    output logic                 o_cpu_rd_return,
    output logic                 o_dma_rd_return,
    output sram_pkg::word_addr_t o_ram_addr,
    output logic                 o_ram_wena,
    output sram_pkg::strb_t      o_ram_strb,
    output sram_pkg::data_t      o_ram_wdata,
    output logic                 o_ram_en
);

    logic last_dma_q;    // DMA won the last contested or single grant
    logic cpu_rd_q;      // RAM output belongs to the CPU port next cycle
    logic dma_rd_q;

    // CPU wins when alone, or when DMA had the previous turn
    assign o_cpu_grant = i_cpu_pend && (!i_dma_pend || last_dma_q);
    assign o_dma_grant = i_dma_pend && (!i_cpu_pend || !last_dma_q);
    assign o_ram_en    = o_cpu_grant || o_dma_grant;

    // Winner's access onto the RAM bus
    assign o_ram_addr  = o_dma_grant ? i_dma_addr  : i_cpu_addr;
    assign o_ram_wena  = o_dma_grant ? i_dma_write : i_cpu_write;
    assign o_ram_strb  = o_dma_grant ? i_dma_strb  : i_cpu_strb;
    assign o_ram_wdata = o_dma_grant ? i_dma_wdata : i_cpu_wdata;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            last_dma_q <= 1'b0;
            cpu_rd_q   <= 1'b0;
            dma_rd_q   <= 1'b0;
        end
        else
        begin
            if (o_ram_en)
            begin
                last_dma_q <= o_dma_grant;
            end
            cpu_rd_q <= o_cpu_grant && !i_cpu_write;   // Read data owner
            dma_rd_q <= o_dma_grant && !i_dma_write;
        end
    end

    assign o_cpu_rd_return = cpu_rd_q;
    assign o_dma_rd_return = dma_rd_q;

    a_one_grant: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_cpu_grant && o_dma_grant));

    a_grant_pending: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!o_cpu_grant || i_cpu_pend) && (!o_dma_grant || i_dma_pend));

endmodule : sram_arbiter

// ==== hdl/sram_dual_top.sv ====
// ==================================================
// Dual-port shared SRAM
// CPU and DMA adapters, arbiter and byte RAM
// ==================================================
module sram_dual_top
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    // CPU master
    input  logic                i_cpu_req_valid,
    input  sram_pkg::bus_addr_t i_cpu_req_addr,
    input  sram_pkg::acc_size_e i_cpu_req_size,
    input  logic                i_cpu_req_write,
    input  sram_pkg::data_t     i_cpu_req_wdata,
    output logic                o_cpu_req_ready,
    output logic                o_cpu_resp_valid,
    output sram_pkg::data_t     o_cpu_resp_rdata,
    output logic                o_cpu_resp_err,
    // DMA master
    input  logic                i_dma_req_valid,
    input  sram_pkg::bus_addr_t i_dma_req_addr,
    input  sram_pkg::acc_size_e i_dma_req_size,
    input  logic                i_dma_req_write,
    input  sram_pkg::data_t     i_dma_req_wdata,
    output logic                o_dma_req_ready,
    output logic                o_dma_resp_valid,
    output sram_pkg::data_t     o_dma_resp_rdata,
    output logic                o_dma_resp_err
);

    import sram_pkg::*;

    logic       cpu_pend;
    word_addr_t cpu_pend_addr;
    logic       cpu_pend_write;
    strb_t      cpu_pend_strb;
    data_t      cpu_pend_wdata;
    logic       cpu_grant;
    logic       cpu_rd_return;
    logic       dma_pend;
    word_addr_t dma_pend_addr;
    logic       dma_pend_write;
    strb_t      dma_pend_strb;
    data_t      dma_pend_wdata;
    logic       dma_grant;
    logic       dma_rd_return;
    word_addr_t ram_addr;
    logic       ram_wena;
    strb_t      ram_strb;
    data_t      ram_wdata;
    logic       ram_en;
    data_t      ram_rdata;     // Shared by both ports, qualified by rd_return

    sram_port u_cpu_port
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req_valid  (i_cpu_req_valid),
        .i_req_addr   (i_cpu_req_addr),
        .i_req_size   (i_cpu_req_size),
        .i_req_write  (i_cpu_req_write),
        .i_req_wdata  (i_cpu_req_wdata),
        .o_req_ready  (o_cpu_req_ready),
        .o_resp_valid (o_cpu_resp_valid),
        .o_resp_rdata (o_cpu_resp_rdata),
        .o_resp_err   (o_cpu_resp_err),
        .o_pend       (cpu_pend),
        .o_pend_addr  (cpu_pend_addr),
        .o_pend_write (cpu_pend_write),
        .o_pend_strb  (cpu_pend_strb),
        .o_pend_wdata (cpu_pend_wdata),
        .i_grant      (cpu_grant),
        .i_rd_return  (cpu_rd_return),
        .i_rd_data    (ram_rdata)
    );

    sram_port u_dma_port
    (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req_valid  (i_dma_req_valid),
        .i_req_addr   (i_dma_req_addr),
        .i_req_size   (i_dma_req_size),
        .i_req_write  (i_dma_req_write),
        .i_req_wdata  (i_dma_req_wdata),
        .o_req_ready  (o_dma_req_ready),
        .o_resp_valid (o_dma_resp_valid),
        .o_resp_rdata (o_dma_resp_rdata),
        .o_resp_err   (o_dma_resp_err),
        .o_pend       (dma_pend),
        .o_pend_addr  (dma_pend_addr),
        .o_pend_write (dma_pend_write),
        .o_pend_strb  (dma_pend_strb),
        .o_pend_wdata (dma_pend_wdata),
        .i_grant      (dma_grant),
        .i_rd_return  (dma_rd_return),
        .i_rd_data    (ram_rdata)
    );

    sram_arbiter u_arbiter
    (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_cpu_pend      (cpu_pend),
        .i_cpu_addr      (cpu_pend_addr),
        .i_cpu_write     (cpu_pend_write),
        .i_cpu_strb      (cpu_pend_strb),
        .i_cpu_wdata     (cpu_pend_wdata),
        .i_dma_pend      (dma_pend),
        .i_dma_addr      (dma_pend_addr),
        .i_dma_write     (dma_pend_write),
        .i_dma_strb      (dma_pend_strb),
        .i_dma_wdata     (dma_pend_wdata),
        .o_cpu_grant     (cpu_grant),
        .o_dma_grant     (dma_grant),
        .o_cpu_rd_return (cpu_rd_return),
        .o_dma_rd_return (dma_rd_return),
        .o_ram_addr      (ram_addr),
        .o_ram_wena      (ram_wena),
        .o_ram_strb      (ram_strb),
        .o_ram_wdata     (ram_wdata),
        .o_ram_en        (ram_en)
    );

    ram_bytes u_ram
    (
        .i_clk   (i_clk),
        .i_en    (ram_en),
        .i_addr  (ram_addr),
        .i_wena  (ram_wena),
        .i_wstrb (ram_strb),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

endmodule : sram_dual_top

// ==== hdl/sram_pkg.sv ====
// ==================================================
// SRAM shared types
// Data, strobe, address and access-size definitions
// ==================================================
`include "sram_settings.svh"

package sram_pkg;

    localparam int DATA_BITS = `SRAM_DATA_BYTES * 8;     // Bits per RAM word
    localparam int LANE_BITS = $clog2(`SRAM_DATA_BYTES); // Byte offset inside a word
    localparam int WORD_BITS = $clog2(`SRAM_WORDS);      // RAM word index width

    typedef logic [31:0] bus_addr_t;                     // Byte address seen by masters
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [`SRAM_DATA_BYTES-1:0] strb_t;         // One bit per byte lane
    typedef logic [WORD_BITS-1:0] word_addr_t;           // Word index into the RAM

    // Access size code carried with each request
    typedef enum logic [1:0]
    {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_e;

endpackage : sram_pkg

// ==== hdl/sram_port.sv ====
// ==================================================
// SRAM port adapter
// Checks one request, builds lanes and strobes
// ==================================================
`include "sram_settings.svh"

module sram_port
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_req_valid,
    input  sram_pkg::bus_addr_t  i_req_addr,
    input  sram_pkg::acc_size_e  i_req_size,
    input  logic                 i_req_write,
    input  sram_pkg::data_t      i_req_wdata,
    output logic                 o_req_ready,
    output logic                 o_resp_valid,   // One-cycle pulse
    output sram_pkg::data_t      o_resp_rdata,
    output logic                 o_resp_err,
    output logic                 o_pend,         // Waiting for the arbiter
    output sram_pkg::word_addr_t o_pend_addr,
    output logic                 o_pend_write,
    output sram_pkg::strb_t      o_pend_strb,
    output sram_pkg::data_t      o_pend_wdata,
    input  logic                 i_grant,        // RAM access happens at this edge
    input  logic                 i_rd_return,    // RAM read word valid now
    input  sram_pkg::data_t      i_rd_data
);

    import sram_pkg::*;

    logic                 accept;
    logic [LANE_BITS-1:0] lane;
    logic                 misaligned;
    logic                 out_of_range;
    strb_t                req_strb;
    data_t                req_lanes;

    logic                 pend_q;
    word_addr_t           pend_addr_q;
    logic                 pend_write_q;
    strb_t                pend_strb_q;
    data_t                pend_wdata_q;
    logic                 rd_wait_q;      // Granted read, data not back yet
    logic                 resp_valid_q;
    logic                 resp_err_q;
    data_t                resp_rdata_q;

    assign o_req_ready  = !(pend_q || rd_wait_q);  // High again in the response cycle
    assign accept       = i_req_valid && o_req_ready;
    assign lane         = i_req_addr[LANE_BITS-1:0];
    assign out_of_range = (i_req_addr[$bits(bus_addr_t)-1:`SRAM_ABITS] != '0);

    // Size decode into byte strobes and replicated lane data
    always_comb
    begin
        misaligned = 1'b0;
        req_strb   = '0;
        req_lanes  = i_req_wdata;
        case (i_req_size)
            SIZE_BYTE:
            begin
                req_strb  = strb_t'(1) << lane;
                req_lanes = {(`SRAM_DATA_BYTES){i_req_wdata[7:0]}};
            end
            SIZE_HALF:
            begin
                misaligned = lane[0];          // Odd byte address
                req_strb   = strb_t'(3) << lane;
                req_lanes  = {(`SRAM_DATA_BYTES/2){i_req_wdata[15:0]}};
            end
            SIZE_WORD:
            begin
                misaligned = (lane != '0);
                req_strb   = '1;
            end
            default:
            begin
                misaligned = 1'b1;             // Reserved size code
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            pend_q       <= 1'b0;
            rd_wait_q    <= 1'b0;
            resp_valid_q <= 1'b0;
            resp_err_q   <= 1'b0;
        end
        else
        begin
            resp_valid_q <= 1'b0;
            resp_err_q   <= 1'b0;
            if (accept && (misaligned || out_of_range))
            begin
                resp_valid_q <= 1'b1;   // Error reply, memory untouched
                resp_err_q   <= 1'b1;
            end
            else if (accept)
            begin
                pend_q <= 1'b1;
            end
            if (i_grant)
            begin
                pend_q       <= 1'b0;
                rd_wait_q    <= !pend_write_q;
                resp_valid_q <= pend_write_q;   // Write ack right after the RAM edge
            end
            if (i_rd_return)
            begin
                rd_wait_q    <= 1'b0;
                resp_valid_q <= 1'b1;
            end
        end
    end

    // Request payload and response word
    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            pend_addr_q  <= i_req_addr[`SRAM_ABITS-1:LANE_BITS];
            pend_write_q <= i_req_write;
            pend_strb_q  <= req_strb;
            pend_wdata_q <= req_lanes;
        end
        resp_rdata_q <= i_rd_return ? i_rd_data : '0;  // Zero on acks and errors
    end

    assign o_pend       = pend_q;
    assign o_pend_addr  = pend_addr_q;
    assign o_pend_write = pend_write_q;
    assign o_pend_strb  = pend_strb_q;
    assign o_pend_wdata = pend_wdata_q;
    assign o_resp_valid = resp_valid_q;
    assign o_resp_err   = resp_err_q;
    assign o_resp_rdata = resp_rdata_q;

    a_ready_not_pend: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_req_ready && o_pend));

    // Arbiter must hand back read data exactly one cycle after the grant
    a_read_returns: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_grant && !pend_write_q) |=> i_rd_return);

endmodule : sram_port

// ==== hdl/sram_settings.svh ====
// ==================================================
// Shared SRAM sizing
// Address span, word width and derived word count
// ==================================================
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// Byte-address bits covered by the RAM, 12 bits give 4 KiB
`define SRAM_ABITS 12

// Bytes per RAM word
`define SRAM_DATA_BYTES 4

// Number of RAM words
`define SRAM_WORDS ((1 << `SRAM_ABITS) / `SRAM_DATA_BYTES)

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the dual-port SRAM testbench with Verilator.
# Exit status is nonzero if the build fails or the testbench stops with $fatal.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_sram_dual \
    --Mdir obj_dir \
    -o tb_sram_dual
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/tb_sram_dual
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit "$sim_status"
fi

exit 0

// ==== tb/tb_sram_dual.sv ====
// ==================================================
// Directed testbench for the dual-port shared SRAM
// Reference byte model, typed checks, contention runs
// ==================================================
`include "sram_settings.svh"

module tb_sram_dual;

    import sram_pkg::*;

    localparam int N_DIRECTED  = 24;     // Sequential directed requests rounded up
    localparam int N_CONTEND   = 300;    // Paired requests in the contention run
    localparam int TXN_CYCLES  = 6;      // Worst case cycles per request slot
    localparam int CYCLE_LIMIT = 10 + (`SRAM_WORDS + N_DIRECTED + N_CONTEND) * TXN_CYCLES;

    logic      clk;
    logic      rst_n;
    logic      cpu_valid;
    bus_addr_t cpu_addr;
    acc_size_e cpu_size;
    logic      cpu_write;
    data_t     cpu_wdata;
    logic      cpu_ready;
    logic      cpu_resp_valid;
    data_t     cpu_resp_rdata;
    logic      cpu_resp_err;
    logic      dma_valid;
    bus_addr_t dma_addr;
    acc_size_e dma_size;
    logic      dma_write;
    data_t     dma_wdata;
    logic      dma_ready;
    logic      dma_resp_valid;
    data_t     dma_resp_rdata;
    logic      dma_resp_err;

    bit [7:0]  ref_mem [0:(1 << `SRAM_ABITS)-1];   // Byte-wide reference memory
    integer    seed;
    int        cycle_cnt;
    int        cpu_req_cnt;
    int        dma_req_cnt;
    int        cpu_resp_cnt;
    int        dma_resp_cnt;

    sram_dual_top i_sram_dual_top
    (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_cpu_req_valid  (cpu_valid),
        .i_cpu_req_addr   (cpu_addr),
        .i_cpu_req_size   (cpu_size),
        .i_cpu_req_write  (cpu_write),
        .i_cpu_req_wdata  (cpu_wdata),
        .o_cpu_req_ready  (cpu_ready),
        .o_cpu_resp_valid (cpu_resp_valid),
        .o_cpu_resp_rdata (cpu_resp_rdata),
        .o_cpu_resp_err   (cpu_resp_err),
        .i_dma_req_valid  (dma_valid),
        .i_dma_req_addr   (dma_addr),
        .i_dma_req_size   (dma_size),
        .i_dma_req_write  (dma_write),
        .i_dma_req_wdata  (dma_wdata),
        .o_dma_req_ready  (dma_ready),
        .o_dma_resp_valid (dma_resp_valid),
        .o_dma_resp_rdata (dma_resp_rdata),
        .o_dma_resp_err   (dma_resp_err)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // Period of 8
    end

    // Response pulses seen on each port at mid-cycle
    always @(negedge clk)
    begin
        if (cpu_resp_valid) cpu_resp_cnt++;
        if (dma_resp_valid) dma_resp_cnt++;
    end

    // Run limit in cycles
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_data(input string what, input data_t got, input data_t exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_err(input string what, input bit got, input bit exp);
        if (got != exp)
            abort_run($sformatf("[ERROR] %0t: %s err got %0b, expected %0b", $time, what, got, exp));
    endtask

    task automatic check_flag(input string what, input bit got, input bit exp);
        if (got != exp)
            abort_run($sformatf("[ERROR] %0t: %s got %0b, expected %0b", $time, what, got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp));
    endtask

    // Little-endian byte writes taken from wdata bit 0 up
    function automatic void ref_write(input bus_addr_t addr, input acc_size_e size,
                                      input data_t wdata);
        int                     nbytes;
        logic [`SRAM_ABITS-1:0] idx;
        data_t                  w;
        nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        idx    = addr[`SRAM_ABITS-1:0];
        w      = wdata;
        for (int i = 0; i < nbytes; i++)
        begin
            ref_mem[idx] = w[7:0];
            w            = w >> 8;
            idx          = idx + 1'b1;
        end
    endfunction

    // Whole word holding addr with lane 0 in the low byte
    function automatic data_t expected_word(input bus_addr_t addr);
        logic [`SRAM_ABITS-1:0] idx;
        data_t                  w;
        idx = {addr[`SRAM_ABITS-1:LANE_BITS], 2'b00};
        w   = '0;
        for (int i = 0; i < 4; i++)
        begin
            w   = {ref_mem[idx], w[31:8]};
            idx = idx + 1'b1;
        end
        return w;
    endfunction

    function automatic data_t fill_word(input bus_addr_t addr);
        return {addr[15:0] ^ 16'h5ac3, ~addr[15:0]};   // Every address bit matters
    endfunction

    function automatic bit port_ready(input bit dma);
        return dma ? dma_ready : cpu_ready;
    endfunction

    function automatic bit resp_seen(input bit dma);
        return dma ? dma_resp_valid : cpu_resp_valid;
    endfunction

    task automatic drive_port(input bit dma, input bit valid, input bus_addr_t addr,
                              input acc_size_e size, input bit write, input data_t wdata);
        if (dma)
        begin
            dma_valid = valid;
            dma_addr  = addr;
            dma_size  = size;
            dma_write = write;
            dma_wdata = wdata;
        end
        else
        begin
            cpu_valid = valid;
            cpu_addr  = addr;
            cpu_size  = size;
            cpu_write = write;
            cpu_wdata = wdata;
        end
    endtask

    // One request on one port and its response fields
    task automatic do_access(input bit dma, input bus_addr_t addr, input acc_size_e size,
                             input bit write, input data_t wdata, input int max_wait,
                             output data_t rdata, output bit err);
        int n;
        n = 0;
        @(negedge clk);
        while (!port_ready(dma))
        begin
            if (n >= 4)
                abort_run("Port stayed busy, request could not be issued");
            @(negedge clk);
            n++;
        end
        drive_port(dma, 1'b1, addr, size, write, wdata);
        if (dma) dma_req_cnt++;
        else     cpu_req_cnt++;
        @(negedge clk);                                    // Accepted at the edge in between
        drive_port(dma, 1'b0, addr, size, write, wdata);
        n = 0;
        while (!resp_seen(dma))
        begin
            if (n >= max_wait)
                abort_run($sformatf("No response on the %s port within %0d cycles",
                                    dma ? "DMA" : "CPU", max_wait));
            @(negedge clk);
            n++;
        end
        rdata = dma ? dma_resp_rdata : cpu_resp_rdata;
        err   = dma ? dma_resp_err : cpu_resp_err;
    endtask

    // Legal request checked against the reference model
    task automatic run_txn(input bit dma, input bus_addr_t addr, input acc_size_e size,
                           input bit write, input data_t wdata);
        data_t rdata;
        bit    err;
        data_t exp;
        exp = expected_word(addr);
        do_access(dma, addr, size, write, wdata, 3, rdata, err);
        check_err(write ? "write response" : "read response", err, 1'b0);
        if (write) ref_write(addr, size, wdata);
        else       check_data("read data", rdata, exp);
    endtask

    task automatic expect_error(input bit dma, input bus_addr_t addr, input acc_size_e size,
                                input bit write, input data_t wdata);
        data_t rdata;
        bit    err;
        do_access(dma, addr, size, write, wdata, 1, rdata, err);
        check_err("illegal request", err, 1'b1);
    endtask

    task automatic verify_reset();
        check_flag("CPU req_ready after reset", cpu_ready, 1'b1);
        check_flag("DMA req_ready after reset", dma_ready, 1'b1);
        check_flag("CPU resp_valid after reset", cpu_resp_valid, 1'b0);
        check_flag("DMA resp_valid after reset", dma_resp_valid, 1'b0);
    endtask

    // Known contents everywhere with the ports taking turns
    task automatic fill_memory();
        bus_addr_t addr;
        for (int w = 0; w < `SRAM_WORDS; w++)
        begin
            addr = bus_addr_t'(w) << LANE_BITS;
            run_txn(w[0], addr, SIZE_WORD, 1'b1, fill_word(addr));
        end
    endtask

    task automatic word_access();
        run_txn(1'b0, 32'h0000_0100, SIZE_WORD, 1'b1, $unsigned($random(seed)));
        run_txn(1'b0, 32'h0000_0100, SIZE_WORD, 1'b0, '0);
        run_txn(1'b1, 32'h0000_0204, SIZE_WORD, 1'b1, $unsigned($random(seed)));
        run_txn(1'b1, 32'h0000_0204, SIZE_WORD, 1'b0, '0);
        run_txn(1'b0, 32'h0000_0204, SIZE_WORD, 1'b0, '0);   // Cross-port read
    endtask

    task automatic sub_word_merge();
        run_txn(1'b0, 32'h0000_0301, SIZE_BYTE, 1'b1, 32'hdead_bec7);  // High bits ignored
        run_txn(1'b1, 32'h0000_0302, SIZE_HALF, 1'b1, 32'h1357_9e4b);
        run_txn(1'b0, 32'h0000_0300, SIZE_WORD, 1'b0, '0);             // Lane 0 untouched
        run_txn(1'b1, 32'h0000_0310, SIZE_HALF, 1'b1, 32'h0000_1234);
        run_txn(1'b1, 32'h0000_0313, SIZE_BYTE, 1'b1, 32'h0000_0056);
        run_txn(1'b1, 32'h0000_0310, SIZE_WORD, 1'b0, '0);
    endtask

    task automatic misaligned_access();
        expect_error(1'b0, 32'h0000_0401, SIZE_HALF, 1'b1, 32'h0000_ffff);
        expect_error(1'b1, 32'h0000_0402, SIZE_WORD, 1'b1, 32'hffff_ffff);
        expect_error(1'b0, 32'h0000_0403, SIZE_WORD, 1'b0, '0);
        run_txn(1'b0, 32'h0000_0400, SIZE_WORD, 1'b0, '0);
    endtask

    task automatic out_of_range_access();
        expect_error(1'b1, 32'h0000_1000, SIZE_WORD, 1'b1, 32'h0bad_0bad);  // First word past RAM
        run_txn(1'b1, 32'h0000_0000, SIZE_WORD, 1'b0, '0);
        expect_error(1'b0, 32'h8000_0080, SIZE_BYTE, 1'b1, 32'h0000_00aa);
        run_txn(1'b0, 32'h0000_0080, SIZE_WORD, 1'b0, '0);
    endtask

    // CPU on even words and DMA on odd words so the model order never matters
    task automatic random_request(input bit dma, output bus_addr_t addr,
                                  output acc_size_e size, output bit write,
                                  output data_t wdata);
        bit [31:0]  r;
        word_addr_t widx;
        r       = $unsigned($random(seed));
        widx    = r[WORD_BITS-1:0];
        widx[0] = dma;
        addr    = '0;
        addr[`SRAM_ABITS-1:LANE_BITS] = widx;
        case (r[13:12])
            2'd0:
            begin
                size       = SIZE_BYTE;
                addr[1:0]  = r[15:14];
            end
            2'd1:
            begin
                size       = SIZE_HALF;
                addr[1:0]  = {r[15], 1'b0};
            end
            default: size = SIZE_WORD;
        endcase
        write = r[16];
        wdata = $unsigned($random(seed));
    endtask

    task automatic contention_run();
        bus_addr_t c_addr;
        acc_size_e c_size;
        bit        c_write;
        data_t     c_wdata;
        bus_addr_t d_addr;
        acc_size_e d_size;
        bit        d_write;
        data_t     d_wdata;
        for (int i = 0; i < N_CONTEND; i++)
        begin
            random_request(1'b0, c_addr, c_size, c_write, c_wdata);
            random_request(1'b1, d_addr, d_size, d_write, d_wdata);
            fork    // Same falling edge on both ports
                run_txn(1'b0, c_addr, c_size, c_write, c_wdata);
                run_txn(1'b1, d_addr, d_size, d_write, d_wdata);
            join
        end
    endtask

    initial
    begin
        seed         = 32'haeaff14e;
        cycle_cnt    = 0;
        cpu_req_cnt  = 0;
        dma_req_cnt  = 0;
        cpu_resp_cnt = 0;
        dma_resp_cnt = 0;
        rst_n        = 1'b0;
        drive_port(1'b0, 1'b0, '0, SIZE_WORD, 1'b0, '0);
        drive_port(1'b1, 1'b0, '0, SIZE_WORD, 1'b0, '0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        verify_reset();
        fill_memory();
        word_access();
        sub_word_merge();
        misaligned_access();
        out_of_range_access();
        contention_run();
        @(negedge clk);                 // Let the last pulse be counted
        check_count("CPU response count", cpu_resp_cnt, cpu_req_cnt);
        check_count("DMA response count", dma_resp_cnt, dma_req_cnt);
        $display("TB PASSED");
        $finish;
    end

endmodule : tb_sram_dual
